// ==== verif/sd_dat_input.txt ====
# name dir(w/r) multiple blocks timeout_value timeout_enable base(hex) preload frames outcome
# preload is the byte count pushed before new_dat, frames the blocks expected on DAT
# data bytes are base plus index, outcome is complete or timeout
single_wr   w 0 1 100 0 a5 4  1 complete
multi_wr    w 1 3 100 0 10 12 3 complete
single_of3  w 0 3 100 0 c0 4  1 complete
read_two    r 1 2 200 1 3c 0  2 complete
wait_buf    w 0 1 100 0 70 2  1 complete
rd_timeout  r 0 1 40  1 00 0  0 timeout
after_tmo   w 1 2 100 0 e8 8  2 complete
read_one    r 0 0 200 0 fe 0  1 complete
blocks_zero w 1 0 100 0 55 4  1 complete

// ==== sd_dat.f ====
design/sd_dat_pkg.sv
design/sd_dat_fifo.sv
design/sd_dat_phys.sv
design/sd_dat_controller.sv
design/sd_dat_top.sv
verif/tb_sd_dat_top.sv

// ==== Bender.yml ====
package:
  name: sd_dat

sources:
  - design/sd_dat_pkg.sv
  - design/sd_dat_fifo.sv
  - design/sd_dat_phys.sv
  - design/sd_dat_controller.sv
  - design/sd_dat_top.sv
  - target: simulation
    files:
      - verif/tb_sd_dat_top.sv

// ==== verif/tb_sd_dat_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sd_dat_top;

  import sd_dat_pkg::*;

  localparam int block_bytes = 4;

  logic         clock;
  logic         reset;
  logic         new_dat;
  sd_xfer_cfg_t req_cfg;
  logic         timeout_enable;
  logic         host_wr_valid;
  logic [7:0]   host_wr_data;
  logic         host_rd;
  logic         dat_in;
  logic         idle;
  logic         transfer_complete;
  logic         timed_out;
  logic [7:0]   host_rd_data;
  logic         host_rd_empty;
  logic         dat_out;
  logic         dat_oe;

  string       vectors[$];
  bit          cap_bits[$];
  int          n_complete;
  int          n_timeout;
  int          errors;
  int          checks;
  int          wd_cycles;
  logic [31:0] rng;

  sd_dat_top dut (
    .clock             (clock),
    .reset             (reset),
    .new_dat           (new_dat),
    .req_cfg           (req_cfg),
    .timeout_enable    (timeout_enable),
    .host_wr_valid     (host_wr_valid),
    .host_wr_data      (host_wr_data),
    .host_rd           (host_rd),
    .dat_in            (dat_in),
    .idle              (idle),
    .transfer_complete (transfer_complete),
    .timed_out         (timed_out),
    .host_rd_data      (host_rd_data),
    .host_rd_empty     (host_rd_empty),
    .dat_out           (dat_out),
    .dat_oe            (dat_oe)
  );

  always #5 clock = ~clock;

  // card side capture and pulse counting on the falling edge
  always @(negedge clock)
  begin
    if (dat_oe)
      cap_bits.push_back(dat_out);
    if (transfer_complete)
      n_complete++;
    if (timed_out)
      n_timeout++;
  end

  task automatic check(input string name, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("Fail %s %s: expected %0h, actual %0h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic next_cycle;
    @(posedge clock);
    #1;
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic parse_vector(input string line, output string name, output int write,
                              output int multiple, output int blocks, output int tmo_value,
                              output int tmo_en, output int base, output int preload,
                              output int frames, output int expect_timeout, output int fields);
    string dir;
    string outcome;
    fields = $sscanf(line, "%s %s %d %d %d %d %h %d %d %s", name, dir, multiple, blocks,
                     tmo_value, tmo_en, base, preload, frames, outcome);
    write          = (dir == "w");
    expect_timeout = (outcome == "timeout");
  endtask

  task automatic load_vectors;
    int    fd;
    string line;
    string name;
    int    write, multiple, blocks, tmo_value, tmo_en;
    int    base, preload, frames, expect_timeout, fields;
    fd = $fopen("verif/sd_dat_input.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the vector file verif/sd_dat_input.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd))
      begin
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          parse_vector(line, name, write, multiple, blocks, tmo_value, tmo_en,
                       base, preload, frames, expect_timeout, fields);
          if (fields != 10)
          begin
            $display("malformed vector line: %s", line);
            errors++;
          end
          else
          begin
            vectors.push_back(line);
            // frame time of every block, the response timeout and some slack
            wd_cycles += ((blocks > 1) ? blocks : 1) * (2 + 8 * block_bytes)
                         + tmo_value + 200;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic push_bytes(input int base, input int first, input int last);
    for (int i = first; i < last; i++)
    begin
      host_wr_valid = 1'b1;
      host_wr_data  = 8'(base + i);
      next_cycle();
    end
    host_wr_valid = 1'b0;
  endtask

  task automatic drive_read(input int base, input int frames);
    int         gap;
    logic [7:0] value;
    rng = xorshift(rng);
    gap = 8 + int'(rng % 8);
    dat_in = 1'b1;
    repeat (gap) next_cycle();
    for (int f = 0; f < frames; f++)
    begin
      dat_in = 1'b0;
      next_cycle();
      for (int b = 0; b < block_bytes; b++)
      begin
        value = 8'(base + f * block_bytes + b);
        for (int k = 7; k >= 0; k--)
        begin
          dat_in = value[k];
          next_cycle();
        end
      end
      // end bit and a short idle gap
      dat_in = 1'b1;
      next_cycle();
      rng = xorshift(rng);
      repeat (int'(rng % 3)) next_cycle();
    end
  endtask

  task automatic check_frames(input string name, input int base, input int frames);
    int         flen;
    int         idx;
    logic [7:0] got;
    flen = 2 + 8 * block_bytes;
    check(name, "captured bits", frames * flen, cap_bits.size());
    if (cap_bits.size() == frames * flen)
    begin
      for (int f = 0; f < frames; f++)
      begin
        idx = f * flen;
        check(name, "start bit", 0, cap_bits[idx]);
        for (int b = 0; b < block_bytes; b++)
        begin
          for (int k = 0; k < 8; k++)
            got = {got[6:0], cap_bits[idx + 1 + 8 * b + k]};
          check(name, "data byte", (base + f * block_bytes + b) & 8'hff, got);
        end
        check(name, "end bit", 1, cap_bits[idx + flen - 1]);
      end
    end
  endtask

  task automatic pop_bytes(input string name, input int base, input int count);
    for (int i = 0; i < count; i++)
    begin
      check(name, "fifo holds data", 0, host_rd_empty);
      check(name, "read byte", (base + i) & 8'hff, host_rd_data);
      host_rd = 1'b1;
      next_cycle();
    end
    host_rd = 1'b0;
  endtask

  task automatic run_test(input string line);
    string name;
    int    write, multiple, blocks, tmo_value, tmo_en;
    int    base, preload, frames, expect_timeout, fields;
    int    total;
    int    limit;
    int    cycles;
    parse_vector(line, name, write, multiple, blocks, tmo_value, tmo_en,
                 base, preload, frames, expect_timeout, fields);
    total                 = frames * block_bytes;
    req_cfg.write         = write[0];
    req_cfg.multiple      = multiple[0];
    req_cfg.blocks        = blocks[3:0];
    req_cfg.timeout_value = tmo_value[15:0];
    timeout_enable        = tmo_en[0];
    next_cycle();
    if (write)
      push_bytes(base, 0, preload);
    cap_bits.delete();
    n_complete = 0;
    n_timeout  = 0;
    check(name, "idle before start", 1, idle);
    check(name, "dat_oe low before start", 0, dat_oe);
    check(name, "dat_out high before start", 1, dat_out);
    new_dat = 1'b1;
    next_cycle();
    new_dat = 1'b0;
    // with a short buffer nothing may leave before the block is complete
    if (write && preload < total)
    begin
      repeat (20) next_cycle();
      check(name, "bits sent before block was loaded", 0, cap_bits.size());
      push_bytes(base, preload, total);
    end
    if (!write)
      drive_read(base, frames);
    limit  = frames * (2 + 8 * block_bytes) + tmo_value + 100;
    cycles = 0;
    while (n_complete + n_timeout == 0 && cycles < limit)
    begin
      next_cycle();
      cycles++;
    end
    if (n_complete + n_timeout == 0)
    begin
      $display("%s: transfer did not end within %0d cycles", name, limit);
      errors++;
    end
    repeat (4) next_cycle();
    check(name, "transfer_complete pulses", expect_timeout ? 0 : 1, n_complete);
    check(name, "timed_out pulses", expect_timeout ? 1 : 0, n_timeout);
    check(name, "idle after transfer", 1, idle);
    if (write)
      check_frames(name, base, frames);
    else
    begin
      check(name, "bits driven during read", 0, cap_bits.size());
      pop_bytes(name, base, total);
    end
    check(name, "fifo empty at end", 1, host_rd_empty);
  endtask

  initial
  begin
    clock          = 1'b0;
    reset          = 1'b1;
    new_dat        = 1'b0;
    req_cfg        = '0;
    timeout_enable = 1'b0;
    host_wr_valid  = 1'b0;
    host_wr_data   = 8'h00;
    host_rd        = 1'b0;
    dat_in         = 1'b1;
    rng            = 32'h446a363f;
    errors         = 0;
    checks         = 0;
    wd_cycles      = 200;
    load_vectors();
    if (vectors.size() == 0)
    begin
      $display("no test vectors were loaded");
      errors++;
    end
    fork
      begin
        repeat (wd_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, the run is stuck", wd_cycles);
        $display("Something failed");
        $finish;
      end
    join_none
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (2) next_cycle();
    // outputs settle to their idle levels once reset is released
    check("reset", "idle", 1, idle);
    check("reset", "dat_oe", 0, dat_oe);
    check("reset", "dat_out", 1, dat_out);
    check("reset", "transfer_complete", 0, transfer_complete);
    check("reset", "timed_out", 0, timed_out);
    check("reset", "host_rd_empty", 1, host_rd_empty);
    foreach (vectors[i])
      run_test(vectors[i]);
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/sd_dat_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sd_dat_top #(
  parameter int block_bytes = 4,
  parameter int fifo_depth  = 16
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       new_dat,
  input  wire sd_dat_pkg::sd_xfer_cfg_t req_cfg,
  input  wire                       timeout_enable,
  input  wire                       host_wr_valid,
  input  wire [7:0]                 host_wr_data,
  input  wire                       host_rd,
  input  wire                       dat_in,
  output logic                      idle,
  output logic                      transfer_complete,
  output logic                      timed_out,
  output logic [7:0]                host_rd_data,
  output logic                      host_rd_empty,
  output logic                      dat_out,
  output logic                      dat_oe
);

  import sd_dat_pkg::*;

  sd_xfer_cfg_t phys_cfg;
  logic         strobe;
  logic         ack;
  logic         serial_ready;
  logic         complete;
  logic         ack_in;
  logic         timeout;
  logic         fifo_okay;
  logic         phys_pop;
  logic         phys_push;
  logic [7:0]   phys_wr_data;

  sd_dat_controller u_controller (
    .clock             (clock),
    .reset             (reset),
    .new_dat           (new_dat),
    .req_cfg           (req_cfg),
    .timeout_enable    (timeout_enable),
    .serial_ready      (serial_ready),
    .complete          (complete),
    .ack_in            (ack_in),
    .timeout           (timeout),
    .fifo_okay         (fifo_okay),
    .phys_cfg          (phys_cfg),
    .idle_out          (idle),
    .strobe_out        (strobe),
    .ack_out           (ack),
    .transfer_complete (transfer_complete),
    .timed_out         (timed_out)
  );

  sd_dat_phys #(
    .block_bytes (block_bytes)
  ) u_phys (
    .clock        (clock),
    .reset        (reset),
    .cfg          (phys_cfg),
    .idle_in      (idle),
    .strobe       (strobe),
    .ack          (ack),
    .dat_in       (dat_in),
    .rd_data      (host_rd_data),
    .serial_ready (serial_ready),
    .complete     (complete),
    .ack_in       (ack_in),
    .timeout      (timeout),
    .dat_out      (dat_out),
    .dat_oe       (dat_oe),
    .pop          (phys_pop),
    .push         (phys_push),
    .wr_data      (phys_wr_data)
  );

  // direction comes from the host request, so loading works before new_dat
  sd_dat_fifo #(
    .block_bytes (block_bytes),
    .fifo_depth  (fifo_depth)
  ) u_fifo (
    .clock     (clock),
    .reset     (reset),
    .write_dir (req_cfg.write),
    .push_a    (host_wr_valid),
    .data_a    (host_wr_data),
    .push_b    (phys_push),
    .data_b    (phys_wr_data),
    .pop_a     (host_rd),
    .pop_b     (phys_pop),
    .head      (host_rd_data),
    .empty     (host_rd_empty),
    .fifo_okay (fifo_okay)
  );

endmodule

`default_nettype wire

// ==== design/sd_dat_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module sd_dat_controller (
  input  wire                       clock,
  input  wire                       reset,
  // host side
  input  wire                       new_dat,
  input  wire sd_dat_pkg::sd_xfer_cfg_t req_cfg,
  input  wire                       timeout_enable,
  // physical layer
  input  wire                       serial_ready,
  input  wire                       complete,
  input  wire                       ack_in,
  input  wire                       timeout,
  // fifo
  input  wire                       fifo_okay,
  output sd_dat_pkg::sd_xfer_cfg_t  phys_cfg,
  output logic                      idle_out,
  output logic                      strobe_out,
  output logic                      ack_out,
  output logic                      transfer_complete,
  output logic                      timed_out
);

  import sd_dat_pkg::*;

  dat_state_e state;
  dat_state_e next_state;
  logic       stop_timeout;

  assign stop_timeout = timeout && timeout_enable;

  always_comb
  begin
    next_state = state;
    case (state)
      st_reset:
        next_state = st_idle;
      st_idle:
      begin
        if (new_dat)
          next_state = st_setting;
      end
      st_setting:
      begin
        if (serial_ready)
          next_state = st_check_fifo;
      end
      st_check_fifo:
      begin
        // waits here until the buffer can take or give a whole block
        if (fifo_okay)
          next_state = st_transmit;
      end
      st_transmit:
      begin
        if (complete)
          next_state = st_ack;
      end
      st_ack:
      begin
        if (ack_in)
          next_state = st_idle;
      end
      default:
        next_state = st_reset;
    endcase
  end

  // reset first, then an enabled timeout aborts from any state
  always_ff @(posedge clock)
  begin
    if (reset)
      state <= st_reset;
    else if (stop_timeout)
      state <= st_idle;
    else
      state <= next_state;
  end

  // request is captured while setting up and held for the whole transfer
  always_ff @(posedge clock)
  begin
    if (reset)
      phys_cfg <= '0;
    else if (state == st_setting)
      phys_cfg <= req_cfg;
  end

  always_comb
  begin
    idle_out   = 1'b0;
    strobe_out = 1'b0;
    ack_out    = 1'b0;
    case (state)
      st_idle:
        idle_out = 1'b1;
      st_transmit:
        strobe_out = 1'b1;
      st_ack:
        ack_out = 1'b1;
      default:
      begin
        idle_out   = 1'b0;
        strobe_out = 1'b0;
        ack_out    = 1'b0;
      end
    endcase
  end

  // ack_in comes back one cycle into st_ack, so this is a single pulse
  assign transfer_complete = (state == st_ack) && ack_in;
  assign timed_out = stop_timeout;

  a_strobe_ack_exclusive : assert property (
    @(posedge clock) disable iff (reset)
    !(strobe_out && ack_out)
  );

  // a request arriving mid-transfer must not restart the sequence
  a_new_dat_ignored : assert property (
    @(posedge clock) disable iff (reset)
    (new_dat && !(state inside {st_idle, st_setting})) |=> state != st_setting
  );

endmodule

`default_nettype wire

// ==== design/sd_dat_phys.sv ====
`timescale 1ns/10ps
`default_nettype none

module sd_dat_phys #(
  parameter int block_bytes = 4
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire sd_dat_pkg::sd_xfer_cfg_t cfg,
  input  wire                       idle_in,
  input  wire                       strobe,
  input  wire                       ack,
  input  wire                       dat_in,
  input  wire [7:0]                 rd_data,
  output logic                      serial_ready,
  output logic                      complete,
  output logic                      ack_in,
  output logic                      timeout,
  output logic                      dat_out,
  output logic                      dat_oe,
  output logic                      pop,
  output logic                      push,
  output logic [7:0]                wr_data
);

  import sd_dat_pkg::*;

  localparam int byte_w = (block_bytes > 1) ? $clog2(block_bytes) : 1;

  phys_state_e       state;
  phys_state_e       next_state;
  logic [7:0]        shift_reg;
  logic [2:0]        bit_cnt;
  logic [byte_w-1:0] byte_cnt;
  logic [3:0]        block_cnt;
  logic [15:0]       timeout_cnt;
  logic [3:0]        block_total;
  logic              last_byte;
  logic              last_block;
  logic              end_ok;

  // a block count of 0, or a single transfer, means one block
  assign block_total = (cfg.multiple && cfg.blocks != 4'd0) ? cfg.blocks : 4'd1;
  assign last_byte   = (byte_cnt == byte_w'(block_bytes - 1));
  assign last_block  = (block_cnt == block_total - 4'd1);
  // writes always close the frame and reads need the end bit high
  assign end_ok      = cfg.write || dat_in;

  always_comb
  begin
    next_state = state;
    case (state)
      ph_idle:
      begin
        if (!idle_in && !strobe && !ack)
          next_state = ph_ready;
      end
      ph_ready:
      begin
        if (idle_in)
          next_state = ph_idle;
        else if (strobe)
          next_state = cfg.write ? ph_start : ph_wait_start;
      end
      ph_start:
        next_state = ph_data;
      ph_data:
      begin
        if (bit_cnt == 3'd7 && last_byte)
          next_state = ph_end;
      end
      ph_end:
      begin
        if (end_ok)
          next_state = last_block ? ph_done : (cfg.write ? ph_start : ph_wait_start);
      end
      ph_wait_start:
      begin
        if (!dat_in)
          next_state = ph_data;
      end
      ph_done:
        next_state = ph_idle;
      default:
        next_state = ph_idle;
    endcase
    // abort once the controller drops the strobe
    if (!strobe && (state inside {ph_start, ph_data, ph_end, ph_wait_start}))
      next_state = ph_idle;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state  <= ph_idle;
      ack_in <= 1'b0;
    end
    else
    begin
      state  <= next_state;
      ack_in <= ack;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      block_cnt   <= '0;
      timeout_cnt <= '0;
    end
    else
    begin
      case (state)
        ph_ready:
        begin
          bit_cnt     <= '0;
          byte_cnt    <= '0;
          block_cnt   <= '0;
          timeout_cnt <= '0;
        end
        ph_data:
        begin
          // wraps to 0 after the eighth bit
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            byte_cnt <= last_byte ? '0 : byte_cnt + byte_w'(1);
        end
        ph_end:
        begin
          if (end_ok)
          begin
            block_cnt   <= block_cnt + 4'd1;
            timeout_cnt <= '0;
          end
        end
        ph_wait_start:
          timeout_cnt <= timeout_cnt + 16'd1;
      endcase
    end
  end

  // write loads the fifo head on bit 0 and read shifts the line in
  always_ff @(posedge clock)
  begin
    if (state == ph_data)
    begin
      if (cfg.write && bit_cnt == 3'd0)
        shift_reg <= {rd_data[6:0], 1'b0};
      else
        shift_reg <= {shift_reg[6:0], cfg.write ? 1'b0 : dat_in};
    end
  end

  assign serial_ready = (state == ph_ready);
  assign complete     = (state == ph_done);
  assign timeout      = (state == ph_wait_start) && (timeout_cnt == cfg.timeout_value);
  assign dat_oe       = cfg.write && (state inside {ph_start, ph_data, ph_end});
  assign pop          = cfg.write && (state == ph_data) && (bit_cnt == 3'd0);
  assign push         = !cfg.write && (state == ph_data) && (bit_cnt == 3'd7);
  assign wr_data      = {shift_reg[6:0], dat_in};

  always_comb
  begin
    dat_out = 1'b1;
    if (dat_oe)
    begin
      case (state)
        ph_start:
          dat_out = 1'b0;
        ph_data:
          dat_out = (bit_cnt == 3'd0) ? rd_data[7] : shift_reg[7];
        default:
          dat_out = 1'b1;
      endcase
    end
  end

  a_pop_in_data : assert property (
    @(posedge clock) disable iff (reset)
    pop |-> (state == ph_data) && strobe
  );

endmodule

`default_nettype wire

// ==== design/sd_dat_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sd_dat_fifo #(
  parameter int block_bytes = 4,
  parameter int fifo_depth  = 16
) (
  input  wire        clock,
  input  wire        reset,
  input  wire        write_dir,
  // port a is the host, port b the physical layer
  input  wire        push_a,
  input  wire [7:0]  data_a,
  input  wire        push_b,
  input  wire [7:0]  data_b,
  input  wire        pop_a,
  input  wire        pop_b,
  output logic [7:0] head,
  output logic       empty,
  output logic       fifo_okay
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  logic [7:0]       mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;
  logic [7:0]       push_data;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1))
      return '0;
    else
      return ptr + ptr_w'(1);
  endfunction

  // host fills and card side drains on a write, the reverse on a read
  assign push      = write_dir ? push_a : push_b;
  assign pop       = write_dir ? pop_b : pop_a;
  assign push_data = write_dir ? data_a : data_b;

  always_ff @(posedge clock)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop)
        count <= count + cnt_w'(1);
      else if (pop && !push)
        count <= count - cnt_w'(1);
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);

  // one whole block stored for a write or room for one for a read
  assign fifo_okay = write_dir ? (count >= cnt_w'(block_bytes))
                               : ((cnt_w'(fifo_depth) - count) >= cnt_w'(block_bytes));

  a_no_push_full : assert property (
    @(posedge clock) disable iff (reset)
    push |-> count != cnt_w'(fifo_depth)
  );

  a_no_pop_empty : assert property (
    @(posedge clock) disable iff (reset)
    pop |-> count != '0
  );

endmodule

`default_nettype wire

// ==== design/sd_dat_pkg.sv ====
`default_nettype none

package sd_dat_pkg;

  // settings of one data transfer as given by the host
  typedef struct packed {
    logic        write;
    logic        multiple;
    logic [3:0]  blocks;
    logic [15:0] timeout_value;
  } sd_xfer_cfg_t;

  // data controller sequence
  typedef enum logic [2:0] {
    st_reset,
    st_idle,
    st_setting,
    st_check_fifo,
    st_transmit,
    st_ack
  } dat_state_e;

  // physical layer moving one DAT bit per clock
  typedef enum logic [2:0] {
    ph_idle,
    ph_ready,
    ph_start,
    ph_data,
    ph_end,
    ph_wait_start,
    ph_done
  } phys_state_e;

endpackage

`default_nettype wire
